//--- bench/cdb_checker.sv
`default_nettype none
`timescale 1ns/1ns

module cdbChecker (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        rdy,
    input wire logic        exEn,
    input wire logic [4:0]  exNick,
    input wire logic [31:0] exData,
    input wire logic        exJump,
    input wire logic [31:0] exJumpPc
);

    int assertFails = 0;

    // ------------------------------
    // Bus output properties
    // ------------------------------

    resetClears: assert property (@(posedge clk) rst |=> !exEn)
        else begin
            $error("exEn is high in the cycle after reset.");
            assertFails++;
        end

    jumpNeedsWrite: assert property (@(posedge clk) disable iff (rst) exJump |-> exEn)
        else begin
            $error("exJump is high while exEn is low.");
            assertFails++;
        end

    // A stalled edge must leave every bus register untouched.
    stallHolds: assert property (@(posedge clk)
        (!rst && !rdy) |=> $stable({exEn, exNick, exData, exJump, exJumpPc}))
        else begin
            $error("Bus outputs changed across a stalled cycle.");
            assertFails++;
        end

    jumpAligned: assert property (@(posedge clk) disable iff (rst) exJump |-> !exJumpPc[0])
        else begin
            $error("exJumpPc bit 0 is set on a jump.");
            assertFails++;
        end

endmodule

`default_nettype wire

//--- bench/exec_patterns.hex
// group_op_pc_imm_rs1_rs2_nick_en_data_jump_jumpPc (the last four are expected outputs)
// Groups: 1 reg-reg, 2 immediate and upper, 3 branches, 4 JAL and JALR, 6 unknown codes.
1_14_00001000_00000123_7fffffff_00000001_01_1_80000000_0_00000000
1_14_00001000_00000123_ffffffff_00000002_02_1_00000001_0_00000000
1_15_00001000_00000123_00000000_00000001_03_1_ffffffff_0_00000000
1_19_00001000_00000123_f0f0f0f0_ff00ff00_04_1_0ff00ff0_0_00000000
1_1c_00001000_00000123_f0f0f0f0_0f000001_05_1_fff0f0f1_0_00000000
1_1d_00001000_00000123_f0f0f0f0_ff00ff00_06_1_f000f000_0_00000000
1_17_00001000_00000123_ffffffff_00000001_07_1_00000001_0_00000000
1_18_00001000_00000123_ffffffff_00000001_08_1_00000000_0_00000000
1_17_00001000_00000123_00000001_80000000_09_1_00000000_0_00000000
1_18_00001000_00000123_00000001_80000000_0a_1_00000001_0_00000000
1_16_00001000_00000123_00000001_00000024_0b_1_00000010_0_00000000
1_1a_00001000_00000123_80000000_ffffffe1_0c_1_40000000_0_00000000
1_1b_00001000_00000123_80000000_0000003f_0d_1_ffffffff_0_00000000
2_0b_00002000_fffffffb_00000005_5a5a5a5a_0e_1_00000000_0_00000000
2_0c_00002000_ffffffff_fffffffe_5a5a5a5a_0f_1_00000001_0_00000000
2_0d_00002000_ffffffff_00000001_5a5a5a5a_10_1_00000001_0_00000000
2_0e_00002000_ffffffff_12345678_5a5a5a5a_11_1_edcba987_0_00000000
2_10_00002000_0000ff00_12345678_5a5a5a5a_12_1_00005600_0_00000000
2_11_00002000_00000021_00000003_5a5a5a5a_13_1_00000006_0_00000000
2_12_00002000_00000004_f0000000_5a5a5a5a_14_1_0f000000_0_00000000
2_13_00002000_00000404_f0000000_5a5a5a5a_15_1_ff000000_0_00000000
2_01_00002000_12345000_00000000_5a5a5a5a_16_1_12345000_0_00000000
2_02_00002000_fffff000_00000000_5a5a5a5a_17_1_00001000_0_00000000
3_05_00004000_00000100_00000007_00000007_18_1_00000000_1_00004100
3_05_00004000_00000100_00000007_00000008_19_1_00000000_0_00000000
3_06_00004000_fffffff0_00000007_00000008_1a_1_00000000_1_00003ff0
3_06_00004000_00000100_00000007_00000007_1b_1_00000000_0_00000000
3_07_00004000_00000100_ffffffff_00000001_1c_1_00000000_1_00004100
3_07_00004000_00000100_00000001_ffffffff_1d_1_00000000_0_00000000
3_08_00004000_00000100_00000001_ffffffff_1e_1_00000000_1_00004100
3_08_00004000_00000100_80000000_7fffffff_1f_1_00000000_0_00000000
3_09_00004000_00000100_00000001_ffffffff_00_1_00000000_1_00004100
3_09_00004000_00000100_ffffffff_00000001_01_1_00000000_0_00000000
3_0a_00004000_00000100_ffffffff_00000001_02_1_00000000_1_00004100
3_0a_00004000_00000100_7fffffff_80000000_03_1_00000000_0_00000000
4_03_00008000_00000200_00000000_00000000_04_1_00008004_1_00008200
4_04_00008000_00000004_00010001_00000000_05_1_00008004_1_00010004
4_04_0000fffc_fffffffe_00020003_00000000_06_1_00010000_1_00020000
6_00_00009000_00000010_11111111_22222222_07_0_00000000_0_00000000
6_1e_00009000_00000010_11111111_22222222_08_0_00000000_0_00000000

//--- bench/executeTb.sv
`default_nettype none
`timescale 1ns/1ns

module executeTb;

    localparam int NumPatterns   = 40;
    localparam int TimeoutCycles = NumPatterns * 5 + 50;
    localparam int HoldGroup     = 5;
    localparam int IdleProbe     = 35;  // A JAL shown with rsEn low at the idle edge.

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        rsEn;
    logic [31:0] rsPc;
    logic [5:0]  rsOp;
    logic [31:0] rsImm;
    logic [4:0]  rsRdNick;
    logic [31:0] rsRs1Data;
    logic [31:0] rsRs2Data;
    logic        exEn;
    logic [4:0]  exNick;
    logic [31:0] exData;
    logic        exJump;
    logic [31:0] exJumpPc;

    // Fields from the top are group, op, pc, imm, rs1, rs2, nick, en, data, jump and jumpPc.
    logic [219:0] patterns [0:NumPatterns-1];
    int           groupChecks [0:7];
    int           groupErrors [0:7];
    int           passCount;
    int           errorCount;
    int           cycleCount;
    integer       seed;

    executeCluster UUT (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .rsEn      (rsEn),
        .rsPc      (rsPc),
        .rsOp      (rsOp),
        .rsImm     (rsImm),
        .rsRdNick  (rsRdNick),
        .rsRs1Data (rsRs1Data),
        .rsRs2Data (rsRs2Data),
        .exEn      (exEn),
        .exNick    (exNick),
        .exData    (exData),
        .exJump    (exJump),
        .exJumpPc  (exJumpPc)
    );

    bind executeCluster cdbChecker cdbCheck (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .exEn     (exEn),
        .exNick   (exNick),
        .exData   (exData),
        .exJump   (exJump),
        .exJumpPc (exJumpPc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic string groupName(input int grp);
        case (grp)
            0:       return "reset state";
            1:       return "register-register ops";
            2:       return "immediate and upper ops";
            3:       return "branches";
            4:       return "JAL and JALR";
            5:       return "stall hold";
            6:       return "unknown codes";
            default: return "other";
        endcase
    endfunction

    function automatic int nextStall();
        return $unsigned($random(seed)) % 4;  // Zero to three rdy-low cycles.
    endfunction

    task automatic compareValue(input int grp, input string name,
                                input logic [31:0] actual, input logic [31:0] expected);
        groupChecks[grp]++;
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            groupErrors[grp]++;
            errorCount++;
        end else begin
            passCount++;
        end
    endtask

    // A negative index stands for the cleared bus after reset.
    task automatic checkOutputs(input int grp, input int idx, input bit issued);
        logic [219:0] vec;
        vec = '0;
        if (idx >= 0) begin
            vec = patterns[idx];
        end
        if (!issued) begin
            vec[71:0] = '0;  // Only the tag is loaded when rsEn was low.
        end
        compareValue(grp, "exEn", 32'(exEn), 32'(vec[68]));
        compareValue(grp, "exNick", 32'(exNick), 32'(vec[76:72]));
        compareValue(grp, "exData", exData, vec[67:36]);
        compareValue(grp, "exJump", 32'(exJump), 32'(vec[32]));
        compareValue(grp, "exJumpPc", exJumpPc, vec[31:0]);
    endtask

    task automatic loadInputs(input int idx, input bit en);
        rsEn      <= en;
        rsOp      <= patterns[idx][213:208];
        rsPc      <= patterns[idx][207:176];
        rsImm     <= patterns[idx][175:144];
        rsRs1Data <= patterns[idx][143:112];
        rsRs2Data <= patterns[idx][111:80];
        rsRdNick  <= patterns[idx][76:72];
    endtask

    task automatic reportGroup(input int grp);
        $display("%s: %0d checks, %0d errors", groupName(grp), groupChecks[grp],
                 groupErrors[grp]);
    endtask

    // ------------------------------
    // Stimulus and checks
    // ------------------------------

    initial begin
        int idx;
        int lastAccepted;
        int stallLeft;
        int curGroup;
        int grp;
        bit accepted;
        bit lastIssued;

        seed       = 32'h4ffc_8424;
        passCount  = 0;
        errorCount = 0;
        for (int g = 0; g < 8; g++) begin
            groupChecks[g] = 0;
            groupErrors[g] = 0;
        end
        rst       <= 1'b1;
        rdy       <= 1'b0;
        rsEn      <= 1'b0;
        rsPc      <= '0;
        rsOp      <= '0;
        rsImm     <= '0;
        rsRdNick  <= '0;
        rsRs1Data <= '0;
        rsRs2Data <= '0;
        $readmemh("bench/exec_patterns.hex", patterns);

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        rdy <= 1'b1;
        loadInputs(IdleProbe, 1'b0);  // Both units have a result while rsEn stays low.
        @(negedge clk);
        checkOutputs(0, -1, 1'b1);
        @(posedge clk);  // Idle ready edge with rsEn low.
        idx          = 0;
        lastAccepted = IdleProbe;
        lastIssued   = 1'b0;
        stallLeft    = nextStall();
        loadInputs(0, 1'b1);
        rdy <= (stallLeft == 0);
        @(negedge clk);
        checkOutputs(0, IdleProbe, 1'b0);
        reportGroup(0);
        curGroup = int'(patterns[0][219:216]);

        while (idx < NumPatterns) begin
            @(posedge clk);
            accepted = (stallLeft == 0);
            if (accepted) begin
                lastAccepted = idx;
                lastIssued   = 1'b1;
                idx++;
                if (idx < NumPatterns) begin
                    stallLeft = nextStall();
                    loadInputs(idx, 1'b1);
                    rdy <= (stallLeft == 0);
                end else begin
                    rsEn <= 1'b0;
                end
            end else begin
                stallLeft--;
                rdy <= (stallLeft == 0);  // The station keeps the operation in place.
            end
            @(negedge clk);
            if (accepted) begin
                grp = int'(patterns[lastAccepted][219:216]);
                if (grp != curGroup) begin
                    reportGroup(curGroup);
                    curGroup = grp;
                end
                checkOutputs(grp, lastAccepted, 1'b1);
            end else begin
                checkOutputs(HoldGroup, lastAccepted, lastIssued);
            end
        end

        reportGroup(curGroup);
        reportGroup(HoldGroup);
        $display("%0d checks passed, %0d errors, %0d assertion failures", passCount,
                 errorCount, UUT.cdbCheck.assertFails);
        if (errorCount == 0 && UUT.cdbCheck.assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles.", TimeoutCycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the execute-stage testbench with Verilator, runs it and checks the log.
rm -f sim.log build.log
verilator --binary --timing --assert --top-module executeTb -f tb.f -o simExec \
    > build.log 2>&1 || { echo "Build failed, see build.log."; exit 1; }
./obj_dir/simExec +verilator+error+limit+100 > sim.log 2>&1
grep -q -F '*** FAILED ***' sim.log && { echo "Simulation failed, see sim.log."; exit 1; }
grep -q -F '*** PASSED ***' sim.log || { echo "Simulation did not finish, see sim.log."; exit 1; }
echo "Simulation passed."

//--- source/aluUnit.sv
`default_nettype none
`timescale 1ns/1ns

module aluUnit (
    input  wire logic [execPkg::AddrWidth-1:0] rsPc,
    input  wire logic [execPkg::OpWidth-1:0]   rsOp,
    input  wire logic [execPkg::DataWidth-1:0] rsImm,
    input  wire logic [execPkg::DataWidth-1:0] rsRs1Data,
    input  wire logic [execPkg::DataWidth-1:0] rsRs2Data,
    output logic      [execPkg::DataWidth-1:0] aluData,
    output logic                               aluHit
);

    import execPkg::*;

    logic                  immForm;
    logic [DataWidth-1:0]  operandB;
    logic [ShamtWidth-1:0] shamt;
    logic [DataWidth-1:0]  sum;
    logic [DataWidth-1:0]  diff;
    logic                  lessSigned;
    logic                  lessUnsigned;
    logic [AddrWidth-1:0]  linkPc;

    // ------------------------------
    // Operand selection
    // ------------------------------

    always_comb begin
        case (rsOp)
            OpAddi, OpSlti, OpSltiu, OpXori, OpOri, OpAndi,
            OpSlli, OpSrli, OpSrai: begin
                immForm = 1'b1;
            end
            default: begin
                immForm = 1'b0;
            end
        endcase
    end

    assign operandB = immForm ? rsImm : rsRs2Data;
    assign shamt    = operandB[ShamtWidth-1:0];  // Upper amount bits are ignored.

    // One adder, one subtractor and one comparator pair serve every code.
    assign sum          = rsRs1Data + operandB;
    assign diff         = rsRs1Data - operandB;
    assign lessSigned   = $signed(rsRs1Data) < $signed(operandB);
    assign lessUnsigned = rsRs1Data < operandB;

    assign linkPc = rsPc + AddrWidth'(4);  // Return address of JAL and JALR.

    // ------------------------------
    // Result select
    // ------------------------------

    always_comb begin
        aluHit  = 1'b1;
        aluData = '0;
        case (rsOp)
            OpLui: begin
                aluData = rsImm;
            end
            OpAuipc: begin
                aluData = rsPc + rsImm;
            end
            OpJal, OpJalr: begin
                aluData = linkPc;
            end
            OpAdd, OpAddi: begin
                aluData = sum;
            end
            OpSub: begin
                aluData = diff;
            end
            OpSlt, OpSlti: begin
                aluData = {{(DataWidth-1){1'b0}}, lessSigned};
            end
            OpSltu, OpSltiu: begin
                aluData = {{(DataWidth-1){1'b0}}, lessUnsigned};
            end
            OpXor, OpXori: begin
                aluData = rsRs1Data ^ operandB;
            end
            OpOr, OpOri: begin
                aluData = rsRs1Data | operandB;
            end
            OpAnd, OpAndi: begin
                aluData = rsRs1Data & operandB;
            end
            OpSll, OpSlli: begin
                aluData = rsRs1Data << shamt;
            end
            OpSrl, OpSrli: begin
                aluData = rsRs1Data >> shamt;
            end
            OpSra, OpSrai: begin
                aluData = $signed(rsRs1Data) >>> shamt;  // Sign bit fills from the left.
            end
            default: begin
                // Branches and unknown codes write no register.
                aluHit = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/branchUnit.sv
`default_nettype none
`timescale 1ns/1ns

module branchUnit (
    input  wire logic [execPkg::AddrWidth-1:0] rsPc,
    input  wire logic [execPkg::OpWidth-1:0]   rsOp,
    input  wire logic [execPkg::DataWidth-1:0] rsImm,
    input  wire logic [execPkg::DataWidth-1:0] rsRs1Data,
    input  wire logic [execPkg::DataWidth-1:0] rsRs2Data,
    output logic                               brHit,
    output logic                               brTaken,
    output logic      [execPkg::AddrWidth-1:0] brTarget
);

    import execPkg::*;

    logic                 equal;
    logic                 lessSigned;
    logic                 lessUnsigned;
    logic [AddrWidth-1:0] pcTarget;
    logic [AddrWidth-1:0] regTarget;
    logic [AddrWidth-1:0] target;

    // ------------------------------
    // Conditions and targets
    // ------------------------------

    assign equal        = rsRs1Data == rsRs2Data;
    assign lessSigned   = $signed(rsRs1Data) < $signed(rsRs2Data);
    assign lessUnsigned = rsRs1Data < rsRs2Data;

    assign pcTarget  = rsPc + rsImm;       // Branches and JAL.
    assign regTarget = rsRs1Data + rsImm;  // JALR, before bit 0 is cleared.

    // ------------------------------
    // Decision
    // ------------------------------

    always_comb begin
        brHit   = 1'b1;
        brTaken = 1'b0;
        target  = pcTarget;
        case (rsOp)
            OpBeq: begin
                brTaken = equal;
            end
            OpBne: begin
                brTaken = !equal;
            end
            OpBlt: begin
                brTaken = lessSigned;
            end
            OpBge: begin
                brTaken = !lessSigned;
            end
            OpBltu: begin
                brTaken = lessUnsigned;
            end
            OpBgeu: begin
                brTaken = !lessUnsigned;
            end
            OpJal: begin
                brTaken = 1'b1;
            end
            OpJalr: begin
                brTaken = 1'b1;
                target  = {regTarget[AddrWidth-1:1], 1'b0};
            end
            default: begin
                brHit = 1'b0;  // Not a control transfer.
            end
        endcase
    end

    // A target is only reported when the jump is taken.
    assign brTarget = brTaken ? target : '0;

endmodule

`default_nettype wire

//--- source/execPkg.sv
`default_nettype none

package execPkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------

    localparam int DataWidth  = 32;                 // Operand and result words.
    localparam int AddrWidth  = 32;                 // Program counter and jump targets.
    localparam int NickWidth  = 5;                  // Reorder-buffer tag of the destination.
    localparam int OpWidth    = 6;                  // Decoded operation code.
    localparam int ShamtWidth = $clog2(DataWidth);  // Shift amount bits that matter.

    // ------------------------------
    // Operation codes
    // ------------------------------

    // The decoder numbers the codes from 1. Zero and anything above OpAnd
    // are not operations this stage knows, and they never reach the bus.

    // Upper immediates and jumps.
    localparam logic [OpWidth-1:0] OpLui   = 6'd1;
    localparam logic [OpWidth-1:0] OpAuipc = 6'd2;
    localparam logic [OpWidth-1:0] OpJal   = 6'd3;
    localparam logic [OpWidth-1:0] OpJalr  = 6'd4;

    // Conditional branches.
    localparam logic [OpWidth-1:0] OpBeq   = 6'd5;
    localparam logic [OpWidth-1:0] OpBne   = 6'd6;
    localparam logic [OpWidth-1:0] OpBlt   = 6'd7;
    localparam logic [OpWidth-1:0] OpBge   = 6'd8;
    localparam logic [OpWidth-1:0] OpBltu  = 6'd9;
    localparam logic [OpWidth-1:0] OpBgeu  = 6'd10;

    // Register-immediate arithmetic.
    localparam logic [OpWidth-1:0] OpAddi  = 6'd11;
    localparam logic [OpWidth-1:0] OpSlti  = 6'd12;
    localparam logic [OpWidth-1:0] OpSltiu = 6'd13;
    localparam logic [OpWidth-1:0] OpXori  = 6'd14;
    localparam logic [OpWidth-1:0] OpOri   = 6'd15;
    localparam logic [OpWidth-1:0] OpAndi  = 6'd16;
    localparam logic [OpWidth-1:0] OpSlli  = 6'd17;
    localparam logic [OpWidth-1:0] OpSrli  = 6'd18;
    localparam logic [OpWidth-1:0] OpSrai  = 6'd19;

    // Register-register arithmetic.
    localparam logic [OpWidth-1:0] OpAdd   = 6'd20;
    localparam logic [OpWidth-1:0] OpSub   = 6'd21;
    localparam logic [OpWidth-1:0] OpSll   = 6'd22;
    localparam logic [OpWidth-1:0] OpSlt   = 6'd23;
    localparam logic [OpWidth-1:0] OpSltu  = 6'd24;
    localparam logic [OpWidth-1:0] OpXor   = 6'd25;
    localparam logic [OpWidth-1:0] OpSrl   = 6'd26;
    localparam logic [OpWidth-1:0] OpSra   = 6'd27;
    localparam logic [OpWidth-1:0] OpOr    = 6'd28;
    localparam logic [OpWidth-1:0] OpAnd   = 6'd29;

endpackage

`default_nettype wire

//--- source/executeCluster.sv
`default_nettype none
`timescale 1ns/1ns

module executeCluster (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               rdy,
    input  wire logic                               rsEn,
    input  wire logic      [execPkg::AddrWidth-1:0] rsPc,
    input  wire logic      [execPkg::OpWidth-1:0]   rsOp,
    input  wire logic      [execPkg::DataWidth-1:0] rsImm,
    input  wire logic      [execPkg::NickWidth-1:0] rsRdNick,
    input  wire logic      [execPkg::DataWidth-1:0] rsRs1Data,
    input  wire logic      [execPkg::DataWidth-1:0] rsRs2Data,
    output logic                                    exEn,
    output logic           [execPkg::NickWidth-1:0] exNick,
    output logic           [execPkg::DataWidth-1:0] exData,
    output logic                                    exJump,
    output logic           [execPkg::AddrWidth-1:0] exJumpPc
);

    import execPkg::*;

    logic [DataWidth-1:0] aluData;
    logic                 aluHit;
    logic                 brHit;
    logic                 brTaken;
    logic [AddrWidth-1:0] brTarget;

    // Both units see the operation in the same cycle.
    aluUnit alu (
        .rsPc      (rsPc),
        .rsOp      (rsOp),
        .rsImm     (rsImm),
        .rsRs1Data (rsRs1Data),
        .rsRs2Data (rsRs2Data),
        .aluData   (aluData),
        .aluHit    (aluHit)
    );

    branchUnit branch (
        .rsPc      (rsPc),
        .rsOp      (rsOp),
        .rsImm     (rsImm),
        .rsRs1Data (rsRs1Data),
        .rsRs2Data (rsRs2Data),
        .brHit     (brHit),
        .brTaken   (brTaken),
        .brTarget  (brTarget)
    );

    resultMerge merge (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .rsEn      (rsEn),
        .rsRdNick  (rsRdNick),
        .aluData   (aluData),
        .aluHit    (aluHit),
        .brHit     (brHit),
        .brTaken   (brTaken),
        .brTarget  (brTarget),
        .exEn      (exEn),
        .exNick    (exNick),
        .exData    (exData),
        .exJump    (exJump),
        .exJumpPc  (exJumpPc)
    );

endmodule

`default_nettype wire

//--- source/resultMerge.sv
`default_nettype none
`timescale 1ns/1ns

module resultMerge (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               rdy,
    input  wire logic                               rsEn,
    input  wire logic      [execPkg::NickWidth-1:0] rsRdNick,
    input  wire logic      [execPkg::DataWidth-1:0] aluData,
    input  wire logic                               aluHit,
    input  wire logic                               brHit,
    input  wire logic                               brTaken,
    input  wire logic      [execPkg::AddrWidth-1:0] brTarget,
    output logic                                    exEn,
    output logic           [execPkg::NickWidth-1:0] exNick,
    output logic           [execPkg::DataWidth-1:0] exData,
    output logic                                    exJump,
    output logic           [execPkg::AddrWidth-1:0] exJumpPc
);

    logic writeValid;
    logic jumpValid;

    // ------------------------------
    // Next-state terms
    // ------------------------------

    // An unknown code hits neither unit, so it falls out here.
    assign writeValid = rsEn && (aluHit || brHit);
    assign jumpValid  = rsEn && brHit && brTaken;

    // ------------------------------
    // Bus registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            exEn     <= 1'b0;
            exNick   <= '0;
            exData   <= '0;
            exJump   <= 1'b0;
            exJumpPc <= '0;
        end else if (rdy) begin
            exEn     <= writeValid;
            exNick   <= rsRdNick;
            exJump   <= jumpValid;

            // Branches arrive with aluData already zero.
            if (writeValid) begin
                exData <= aluData;
            end else begin
                exData <= '0;
            end

            if (jumpValid) begin
                exJumpPc <= brTarget;
            end else begin
                exJumpPc <= '0;
            end
        end
        // With rdy low every register keeps its value.
    end

endmodule

`default_nettype wire

//--- tb.f
source/execPkg.sv
source/aluUnit.sv
source/branchUnit.sv
source/resultMerge.sv
source/executeCluster.sv
bench/cdb_checker.sv
bench/executeTb.sv
